// ==== verilog/merge_pkg.sv ====
`default_nettype none

package merge_pkg;

    // Lane word width.
    localparam int DATA_W = 32;

    // Width of the delay, stride and length counts.
    localparam int CNT_W = 16;

    // Largest lane count the lane index can address.
    localparam int MAX_LANES = 16;

    localparam int LANE_W = $clog2(MAX_LANES);

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [CNT_W-1:0] cnt_t;

    typedef logic [LANE_W-1:0] lane_t;

    // Run configuration, sampled together with the run strobe.
    typedef struct packed {
        cnt_t delay0; // Cycles spent on lane 0 before striding starts.
        cnt_t stride; // Extra cycles spent on each lane.
        cnt_t length; // Number of running cycles.
    } merge_cfg_t;

    // One merged word with the lane it was taken from.
    typedef struct packed {
        logic  valid;
        lane_t lane;
        data_t data;
    } merge_out_t;

    typedef enum logic {
        IDLE,
        RUNNING
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/merge_run_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module merge_run_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  run,
    input  wire merge_pkg::merge_cfg_t cfg,
    output logic                       running,
    output logic                       start,
    output merge_pkg::merge_cfg_t      cfg_q,
    output logic                       done
);

    merge_pkg::ctrl_state_t state;
    merge_pkg::cnt_t        remaining;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= merge_pkg::IDLE;
            remaining <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
        end else begin
            start <= run;
            done  <= 1'b0;
            if (run) begin
                remaining <= cfg.length; // A run always restarts the window.
                if (state == merge_pkg::RUNNING && remaining == merge_pkg::cnt_t'(1)) begin
                    done <= 1'b1; // The old window ends in this cycle and still completes.
                end
                if (cfg.length == '0) begin
                    state <= merge_pkg::IDLE;
                    done  <= 1'b1; // An empty window completes at once.
                end else begin
                    state <= merge_pkg::RUNNING;
                end
            end else if (state == merge_pkg::RUNNING) begin
                remaining <= remaining - 1'b1;
                if (remaining == merge_pkg::cnt_t'(1)) begin
                    state <= merge_pkg::IDLE;
                    done  <= 1'b1; // Lines up with the last merged word.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            cfg_q <= cfg;
        end
    end

    assign running = (state == merge_pkg::RUNNING);

    // Done and running overlap only when a run lands on the last cycle of the old window.
    a_done_overlap: assert property (
        @(posedge clk) disable iff (rst)
        (done && running) |-> $past(run)
    );

endmodule

`default_nettype wire

// ==== verilog/lane_skew.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_skew #(
    parameter int LANES = 16
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire merge_pkg::data_t [LANES-1:0]      lanes_in,
    output merge_pkg::data_t      [LANES-1:0]      lanes_aligned
);

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign lanes_aligned[0] = lanes_in[0]; // Lane 0 has no latency.
        end else begin : g_delay
            merge_pkg::data_t [k-1:0] pipe;

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    pipe <= '0;
                end else begin
                    pipe[0] <= lanes_in[k];
                    for (int i = 1; i < k; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            // The oldest stage is exactly k cycles behind the producer.
            assign lanes_aligned[k] = pipe[k-1];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/strided_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module strided_merge #(
    parameter int LANES = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire logic                          running,
    input  wire merge_pkg::merge_cfg_t         cfg_q,
    input  wire merge_pkg::data_t [LANES-1:0] lanes_aligned,
    output merge_pkg::merge_out_t              merged
);

    if (LANES < 1 || LANES > merge_pkg::MAX_LANES) begin : g_lanes_check
        $error("strided_merge: LANES must be between 1 and MAX_LANES");
    end

    merge_pkg::cnt_t  delay_q;
    merge_pkg::cnt_t  stride_q;
    merge_pkg::lane_t lane_q;

    merge_pkg::cnt_t  delay_cur;
    merge_pkg::cnt_t  stride_cur;
    merge_pkg::lane_t lane_cur;
    merge_pkg::lane_t lane_next;

    // In the start cycle the counters have not been loaded yet, so the fresh
    // configuration stands in for them.
    always_comb begin
        if (start) begin
            delay_cur  = cfg_q.delay0;
            stride_cur = cfg_q.stride;
            lane_cur   = '0;
        end else begin
            delay_cur  = delay_q;
            stride_cur = stride_q;
            lane_cur   = lane_q;
        end
    end

    assign lane_next = (lane_cur == merge_pkg::lane_t'(LANES - 1)) ? '0 : lane_cur + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delay_q  <= '0;
            stride_q <= '0;
            lane_q   <= '0;
        end else if (running) begin
            if (delay_cur != '0) begin
                delay_q  <= delay_cur - 1'b1; // Still holding lane 0.
                stride_q <= stride_cur;
                lane_q   <= '0;
            end else if (stride_cur != '0) begin
                delay_q  <= '0;
                stride_q <= stride_cur - 1'b1; // Stay on the current lane.
                lane_q   <= lane_cur;
            end else begin
                delay_q  <= '0;
                stride_q <= cfg_q.stride;
                lane_q   <= lane_next; // Stride used up, move on and wrap.
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            merged <= '0;
        end else begin
            merged.valid <= running;
            merged.lane  <= running ? lane_cur : '0;
            merged.data  <= running ? lanes_aligned[lane_cur] : '0;
        end
    end

    a_lane_range: assert property (
        @(posedge clk) disable iff (rst)
        32'(lane_q) < LANES
    );

    // Valid words only ever trail the controller's running window by one cycle.
    a_valid_window: assert property (
        @(posedge clk) disable iff (rst)
        merged.valid |-> $past(running)
    );

endmodule

`default_nettype wire

// ==== verilog/merge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module merge_top #(
    parameter int LANES = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          run,
    input  wire merge_pkg::merge_cfg_t         cfg,
    input  wire merge_pkg::data_t [LANES-1:0] lanes_in,
    output merge_pkg::merge_out_t              merged,
    output logic                               done
);

    logic                         running;
    logic                         start;
    merge_pkg::merge_cfg_t        cfg_q;
    merge_pkg::data_t [LANES-1:0] lanes_aligned;

    merge_run_ctrl i_ctrl (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .cfg     (cfg),
        .running (running),
        .start   (start),
        .cfg_q   (cfg_q),
        .done    (done)
    );

    // Lane k arrives k cycles late, matching the producer latencies.
    lane_skew #(
        .LANES (LANES)
    ) i_skew (
        .clk           (clk),
        .rst           (rst),
        .lanes_in      (lanes_in),
        .lanes_aligned (lanes_aligned)
    );

    strided_merge #(
        .LANES (LANES)
    ) i_merge (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .running       (running),
        .cfg_q         (cfg_q),
        .lanes_aligned (lanes_aligned),
        .merged        (merged)
    );

endmodule

`default_nettype wire

// ==== tests/merge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module merge_tb;

    localparam int LANES       = 16;
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int RAND_RUNS   = 16;
    localparam int DONE_SLACK  = 8;
    localparam int MARGIN      = 100;

    // Every test's run lengths, plus run and settle cycles, plus a margin.
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 22 + 44 + 84 + 4 + 124
                                     + RAND_RUNS * 65 + MARGIN;

    // Junk configuration driven while run is low; the DUT must ignore it.
    localparam merge_pkg::merge_cfg_t IDLE_CFG = '1;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         run;
    merge_pkg::merge_cfg_t        cfg;
    merge_pkg::data_t [LANES-1:0] lanes_in;
    merge_pkg::merge_out_t        merged;
    logic                         done;

    logic [31:0] lfsr_state = 32'hdfcc;

    int err_count   = 0;
    int check_count = 0;
    int test_count  = 0;

    // Lane inputs seen at each falling edge and indexed by slot.
    merge_pkg::data_t [LANES-1:0] hist_q[$];

    int                    slot        = 0;
    logic                  cur_active  = 1'b0;
    int                    cur_rs      = 0;
    merge_pkg::merge_cfg_t cur_cfg     = '0;
    logic                  prev_active = 1'b0;
    int                    prev_rs     = 0;
    int                    prev_last   = 0;
    merge_pkg::merge_cfg_t prev_cfg    = '0;

    merge_top #(
        .LANES (LANES)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .cfg      (cfg),
        .lanes_in (lanes_in),
        .merged   (merged),
        .done     (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // Lane k reaches the merge stage k cycles late, so its word comes from an older slot.
    function automatic merge_pkg::merge_out_t expected_word(input int n,
                                                           input merge_pkg::cnt_t delay0,
                                                           input merge_pkg::cnt_t stride,
                                                           input int slot_now);
        merge_pkg::merge_out_t word;
        int                    lane;
        int                    idx;
        if (n < int'(delay0)) begin
            lane = 0;
        end else begin
            lane = ((n - int'(delay0)) / (int'(stride) + 1)) % LANES;
        end
        idx        = slot_now - 1 - lane;
        word.valid = 1'b1;
        word.lane  = merge_pkg::lane_t'(lane);
        word.data  = (idx >= 0) ? hist_q[idx][lane] : '0;
        return word;
    endfunction

    always @(negedge clk) begin : compare
        merge_pkg::merge_out_t exp_w;
        merge_pkg::merge_cfg_t w_cfg;
        logic                  exp_valid;
        logic                  exp_done;
        int                    w_rs;
        hist_q.push_back(lanes_in);
        if (!rst) begin
            exp_valid = 1'b0;
            w_rs      = 0;
            w_cfg     = '0;
            if (cur_active && slot >= cur_rs + 2 && slot <= cur_rs + 1 + int'(cur_cfg.length)) begin
                exp_valid = 1'b1;
                w_rs      = cur_rs;
                w_cfg     = cur_cfg;
            end else if (prev_active && slot >= prev_rs + 2 && slot <= prev_last) begin
                exp_valid = 1'b1; // Tail of a window cut short by a restart.
                w_rs      = prev_rs;
                w_cfg     = prev_cfg;
            end
            exp_done = cur_active && (slot == cur_rs + 1 + int'(cur_cfg.length));
            if (prev_active && slot == prev_last
                    && prev_last == prev_rs + 1 + int'(prev_cfg.length)) begin
                exp_done = 1'b1; // The old window ran to its end as the restart came in.
            end
            check_count++;
            if (exp_valid) begin
                exp_w = expected_word(slot - w_rs - 2, w_cfg.delay0, w_cfg.stride, slot);
                if (!merged.valid) begin
                    $display("ERR %0t: valid low in slot %0d inside the window", $time, slot);
                    err_count++;
                end else if (merged.lane != exp_w.lane || merged.data != exp_w.data) begin
                    $display("ERR %0t: slot %0d got lane %0d data %h, expected lane %0d data %h",
                             $time, slot, merged.lane, merged.data, exp_w.lane, exp_w.data);
                    err_count++;
                end
            end else if (merged.valid || merged.lane != '0 || merged.data != '0) begin
                $display("ERR %0t: slot %0d word outside the window, valid %0b lane %0d data %h",
                         $time, slot, merged.valid, merged.lane, merged.data);
                err_count++;
            end
            if (done != exp_done) begin
                $display("ERR %0t: slot %0d done is %0b, expected %0b", $time, slot, done, exp_done);
                err_count++;
            end
            if (run) begin
                prev_active = cur_active;
                prev_rs     = cur_rs;
                prev_cfg    = cur_cfg;
                prev_last   = cur_rs + 1 + int'(cur_cfg.length);
                if (prev_last > slot + 1) begin
                    prev_last = slot + 1;
                end
                cur_active = 1'b1;
                cur_rs     = slot;
                cur_cfg    = cfg;
            end
        end
        slot++;
    end

    task automatic step(input logic run_v, input merge_pkg::merge_cfg_t cfg_v);
        int k;
        @(posedge clk);
        #(DRIVE_DELAY);
        run = run_v;
        cfg = run_v ? cfg_v : IDLE_CFG;
        for (k = 0; k < LANES; k++) begin
            lanes_in[k] = merge_pkg::data_t'(rand_bits(32));
        end
    endtask

    task automatic step_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            step(1'b0, IDLE_CFG);
        end
    endtask

    task automatic wait_done(input int expected_cycles);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < expected_cycles + DONE_SLACK) begin
            step(1'b0, IDLE_CFG);
            @(negedge clk);
            waited++;
            if (done) begin
                seen = 1'b1;
            end
        end
        check_count++;
        if (!seen) begin
            $display("Done strobe never arrived within %0d cycles of the run strobe", waited);
            err_count++;
        end else if (waited != expected_cycles) begin
            $display("ERR %0t: done came %0d cycles after run, expected %0d",
                     $time, waited, expected_cycles);
            err_count++;
        end
    endtask

    task automatic single_run(input int delay0, input int stride, input int length);
        merge_pkg::merge_cfg_t c;
        c.delay0 = merge_pkg::cnt_t'(delay0);
        c.stride = merge_pkg::cnt_t'(stride);
        c.length = merge_pkg::cnt_t'(length);
        step(1'b1, c);
        wait_done(length + 1);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name, err_count - errs_before);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        merge_pkg::merge_cfg_t c;
        int                    errs;
        int                    r;
        rst      = 1'b1;
        run      = 1'b0;
        cfg      = '0;
        lanes_in = '0;
        step_idle(RST_CYCLES);
        rst = 1'b0;

        errs = err_count;
        step_idle(20);
        report_test("idle after reset", errs);

        errs = err_count;
        single_run(0, 0, 40);
        step_idle(2);
        report_test("stride 0 with wrap", errs);

        errs = err_count;
        single_run(5, 3, 80);
        step_idle(2);
        report_test("delay 5 stride 3", errs);

        errs = err_count;
        single_run(0, 0, 0);
        step_idle(2);
        report_test("zero length", errs);

        errs     = err_count;
        c.delay0 = 16'd2;
        c.stride = 16'd1;
        c.length = 16'd60;
        step(1'b1, c);
        step_idle(25);
        single_run(3, 2, 50); // Restart in the middle of the first window.
        c.delay0 = 16'd1;
        c.stride = 16'd0;
        c.length = 16'd12;
        step(1'b1, c);
        step_idle(11);
        c.delay0 = 16'd4;
        c.stride = 16'd2;
        c.length = 16'd30;
        step(1'b1, c); // Lands on the last running cycle, so the old window still ends with done.
        step_idle(1);
        wait_done(30);
        step_idle(2);
        report_test("restart mid-window", errs);

        errs = err_count;
        for (r = 0; r < RAND_RUNS; r++) begin
            single_run(int'(rand_bits(3)), int'(rand_bits(2)), int'(rand_bits(6)));
        end
        step_idle(2);
        report_test("random back to back", errs);

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/merge_pkg.sv
verilog/merge_run_ctrl.sv
verilog/lane_skew.sv
verilog/strided_merge.sv
verilog/merge_top.sv
tests/merge_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := merge_tb
FILE_LIST  := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
